/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mem_port
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert
EXTRA     ?=

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) $(EXTRA) -j $(JOBS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* design/avl_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module avl_sequencer (
  input  wire logic                    clk_i,
  input  wire logic                    rst_i,

  input  wire mem_port_pkg::mem_cmd_t  cmd_i,
  input  wire logic                    cmd_empty_i,
  output logic                         cmd_pop_o,

  output logic                         rsp_push_o,
  output mem_port_pkg::mem_data_t      rsp_o,
  input  wire logic                    rsp_full_i,

  input  wire logic                    avl_ready_i,
  output mem_port_pkg::mem_addr_t      avl_addr_o,
  output mem_port_pkg::mem_data_t      avl_wdata_o,
  output logic                         avl_read_req_o,
  output logic                         avl_write_req_o,
  output logic                   [8:0] avl_size_o,
  input  wire logic                    avl_rdata_valid_i,
  input  wire mem_port_pkg::mem_data_t avl_rdata_i
);

  mem_port_pkg::seq_state_t state_q;
  logic                     cmd_we;
  mem_port_pkg::mem_addr_t  cmd_adr;
  mem_port_pkg::mem_data_t  cmd_dat;

  assign {cmd_we, cmd_adr, cmd_dat} = cmd_i;

  // a read is only started when its beat has somewhere to go
  assign cmd_pop_o = (state_q == mem_port_pkg::SEQ_IDLE) && !cmd_empty_i && !rsp_full_i;

  assign rsp_push_o = (state_q == mem_port_pkg::SEQ_RDATA) && avl_rdata_valid_i;
  assign rsp_o      = avl_rdata_i;
  assign avl_size_o = 9'd1; // single beat bursts only

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      state_q         <= mem_port_pkg::SEQ_IDLE;
      avl_read_req_o  <= 1'b0;
      avl_write_req_o <= 1'b0;
    end
    else
    begin
      case (state_q)
        mem_port_pkg::SEQ_IDLE:
          if (cmd_pop_o)
          begin
            avl_read_req_o  <= !cmd_we;
            avl_write_req_o <= cmd_we;
            state_q         <= mem_port_pkg::SEQ_CMD;
          end
        mem_port_pkg::SEQ_CMD:
          if (avl_ready_i) // the controller takes the command in this cycle
          begin
            avl_read_req_o  <= 1'b0;
            avl_write_req_o <= 1'b0;
            state_q         <= avl_read_req_o ? mem_port_pkg::SEQ_RDATA : mem_port_pkg::SEQ_IDLE;
          end
        mem_port_pkg::SEQ_RDATA:
          if (avl_rdata_valid_i)
            state_q <= mem_port_pkg::SEQ_IDLE;
        default:
          state_q <= mem_port_pkg::SEQ_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_pop_o)
    begin
      avl_addr_o  <= cmd_adr;
      avl_wdata_o <= cmd_dat;
    end
  end

  a_one_req: assert property (@(posedge clk_i) disable iff (rst_i)
    !(avl_read_req_o && avl_write_req_o));

  // controller may sample the command in any cycle until ready
  a_hold_cmd: assert property (@(posedge clk_i) disable iff (rst_i)
    (avl_read_req_o || avl_write_req_o) && !avl_ready_i |=>
      $stable(avl_addr_o) && $stable(avl_read_req_o) && $stable(avl_write_req_o));

endmodule

`default_nettype wire

/* design/icache.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_port_cfg.svh"

module icache (
  input  wire logic                    clk_i,
  input  wire logic                    rst_i,
  input  wire logic                    flush_i,

  input  wire logic                    core_stb_i,
  input  wire mem_port_pkg::mem_addr_t core_adr_i,
  output logic                         core_stall_o,
  output logic                         core_ack_o,
  output mem_port_pkg::mem_data_t      core_rdat_o,

  output logic                         mem_stb_o,
  output mem_port_pkg::mem_addr_t      mem_adr_o,
  input  wire logic                    mem_stall_i,
  input  wire logic                    mem_ack_i,
  input  wire mem_port_pkg::mem_data_t mem_rdat_i
);

  localparam int IDX_W = $clog2(`ICACHE_LINES);

  mem_port_pkg::icache_state_t state_q;
  logic [`ICACHE_LINES-1:0]    valid_q;
  mem_port_pkg::icache_tag_t   tag_mem [`ICACHE_LINES];
  mem_port_pkg::mem_data_t     data_mem [`ICACHE_LINES];
  mem_port_pkg::mem_addr_t     adr_q;
  mem_port_pkg::mem_data_t     rdat_q;
  logic                        lookup_q; // accepted request waiting for its tag compare
  logic                        mem_stb_q;
  logic                        flush_pend_q;
  logic                        ack_q;
  logic [IDX_W-1:0]            idx;
  mem_port_pkg::icache_tag_t   tag;
  logic                        hit;
  logic                        accept;
  logic                        fill_done;

  assign idx = adr_q[IDX_W-1:0];
  assign tag = adr_q[`MEM_ADDR_W-1:IDX_W];
  assign hit = valid_q[idx] && (tag_mem[idx] == tag);

  assign core_stall_o = (state_q != mem_port_pkg::IC_LOOKUP) || lookup_q;
  assign accept       = core_stb_i && !core_stall_o;
  assign fill_done    = (state_q == mem_port_pkg::IC_FILL) && mem_ack_i;

  assign core_ack_o  = ack_q;
  assign core_rdat_o = rdat_q;
  assign mem_stb_o   = mem_stb_q;
  assign mem_adr_o   = adr_q;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      state_q      <= mem_port_pkg::IC_LOOKUP;
      valid_q      <= '0;
      lookup_q     <= 1'b0;
      mem_stb_q    <= 1'b0;
      flush_pend_q <= 1'b0;
      ack_q        <= 1'b0;
    end
    else
    begin
      ack_q    <= 1'b0;
      lookup_q <= accept;
      if (state_q == mem_port_pkg::IC_LOOKUP)
      begin
        if (lookup_q && hit)
          ack_q <= 1'b1;
        else if (lookup_q)
        begin
          mem_stb_q <= 1'b1;
          state_q   <= mem_port_pkg::IC_FILL;
        end
        if (flush_i)
          valid_q <= '0;
      end
      else
      begin
        if (flush_i)
          flush_pend_q <= 1'b1;
        if (mem_stb_q && !mem_stall_i)
          mem_stb_q <= 1'b0;
        if (fill_done)
        begin
          ack_q        <= 1'b1;
          flush_pend_q <= 1'b0;
          state_q      <= mem_port_pkg::IC_LOOKUP;
          // a flush seen during the fill wipes the new line as well
          if (flush_pend_q || flush_i)
            valid_q <= '0;
          else
            valid_q[idx] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
      adr_q <= core_adr_i;
    if (lookup_q)
      rdat_q <= data_mem[idx];
    if (fill_done)
    begin
      tag_mem[idx]  <= tag;
      data_mem[idx] <= mem_rdat_i;
      rdat_q        <= mem_rdat_i; // fetched word goes straight to the core
    end
  end

endmodule

`default_nettype wire

/* design/mem_port_cfg.svh */
`ifndef MEM_PORT_CFG_SVH
`define MEM_PORT_CFG_SVH

// word address into the DDR controller, one word per address
`define MEM_ADDR_W 26

// one Avalon beat
`define MEM_DATA_W 128

// posted writes can pile up here while the controller is busy
`define CMD_FIFO_DEPTH 4
`define RSP_FIFO_DEPTH 2

`define ICACHE_LINES 16 // must be a power of two

`endif

/* design/mem_port_pkg.sv */
`default_nettype none

`include "mem_port_cfg.svh"

package mem_port_pkg;

  typedef logic [`MEM_ADDR_W-1:0] mem_addr_t;
  typedef logic [`MEM_DATA_W-1:0] mem_data_t;

  // {we, addr, data} as pushed into the command FIFO
  typedef logic [`MEM_ADDR_W+`MEM_DATA_W:0] mem_cmd_t;

  typedef logic [`MEM_ADDR_W-$clog2(`ICACHE_LINES)-1:0] icache_tag_t; // address above the index

  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_POST,
    ARB_WAIT_RSP
  } arb_state_t;

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_CMD,
    SEQ_RDATA
  } seq_state_t;

  typedef enum logic {
    IC_LOOKUP,
    IC_FILL
  } icache_state_t;

endpackage

`default_nettype wire

/* design/mem_port_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_port_cfg.svh"

module mem_port_top (
  input  wire logic                    clk,
  input  wire logic                    rst,
  input  wire logic                    flush_i,

  input  wire logic                    inst_stb_i,
  input  wire mem_port_pkg::mem_addr_t inst_adr_i,
  output logic                         inst_stall_o,
  output logic                         inst_ack_o,
  output mem_port_pkg::mem_data_t      inst_rdat_o,

  input  wire logic                    data_stb_i,
  input  wire logic                    data_we_i,
  input  wire mem_port_pkg::mem_addr_t data_adr_i,
  input  wire mem_port_pkg::mem_data_t data_wdat_i,
  output logic                         data_stall_o,
  output logic                         data_ack_o,
  output mem_port_pkg::mem_data_t      data_rdat_o,

  input  wire logic                    avl_ready_i,
  output mem_port_pkg::mem_addr_t      avl_addr_o,
  output mem_port_pkg::mem_data_t      avl_wdata_o,
  output logic                         avl_read_req_o,
  output logic                         avl_write_req_o,
  output logic                   [8:0] avl_size_o,
  input  wire logic                    avl_rdata_valid_i,
  input  wire mem_port_pkg::mem_data_t avl_rdata_i
);

  // cache misses towards the arbiter
  logic                    miss_stb;
  mem_port_pkg::mem_addr_t miss_adr;
  logic                    miss_stall;
  logic                    miss_ack;
  mem_port_pkg::mem_data_t miss_rdat;

  logic                    cmd_push;
  logic                    cmd_pop;
  logic                    cmd_full;
  logic                    cmd_empty;
  mem_port_pkg::mem_cmd_t  cmd_in;
  mem_port_pkg::mem_cmd_t  cmd_out;

  logic                    rsp_push;
  logic                    rsp_pop;
  logic                    rsp_full;
  logic                    rsp_empty;
  mem_port_pkg::mem_data_t rsp_in;
  mem_port_pkg::mem_data_t rsp_out;

  icache icache_i (
    .clk_i (clk), .rst_i (rst), .flush_i (flush_i),
    .core_stb_i (inst_stb_i), .core_adr_i (inst_adr_i), .core_stall_o (inst_stall_o),
    .core_ack_o (inst_ack_o), .core_rdat_o (inst_rdat_o),
    .mem_stb_o (miss_stb), .mem_adr_o (miss_adr), .mem_stall_i (miss_stall),
    .mem_ack_i (miss_ack), .mem_rdat_i (miss_rdat)
  );

  req_arbiter arbiter_i (
    .clk_i (clk), .rst_i (rst),
    .inst_stb_i (miss_stb), .inst_adr_i (miss_adr), .inst_stall_o (miss_stall),
    .inst_ack_o (miss_ack), .inst_rdat_o (miss_rdat),
    .data_stb_i (data_stb_i), .data_we_i (data_we_i), .data_adr_i (data_adr_i),
    .data_wdat_i (data_wdat_i), .data_stall_o (data_stall_o),
    .data_ack_o (data_ack_o), .data_rdat_o (data_rdat_o),
    .cmd_push_o (cmd_push), .cmd_o (cmd_in), .cmd_full_i (cmd_full),
    .rsp_pop_o (rsp_pop), .rsp_i (rsp_out), .rsp_empty_i (rsp_empty)
  );

  sync_fifo #(.WIDTH($bits(mem_port_pkg::mem_cmd_t)), .DEPTH(`CMD_FIFO_DEPTH)) cmd_fifo (
    .clk_i (clk), .rst_i (rst),
    .push_i (cmd_push), .din_i (cmd_in), .full_o (cmd_full),
    .pop_i (cmd_pop), .dout_o (cmd_out), .empty_o (cmd_empty)
  );

  sync_fifo #(.WIDTH($bits(mem_port_pkg::mem_data_t)), .DEPTH(`RSP_FIFO_DEPTH)) rsp_fifo (
    .clk_i (clk), .rst_i (rst),
    .push_i (rsp_push), .din_i (rsp_in), .full_o (rsp_full),
    .pop_i (rsp_pop), .dout_o (rsp_out), .empty_o (rsp_empty)
  );

  avl_sequencer sequencer_i (
    .clk_i (clk), .rst_i (rst),
    .cmd_i (cmd_out), .cmd_empty_i (cmd_empty), .cmd_pop_o (cmd_pop),
    .rsp_push_o (rsp_push), .rsp_o (rsp_in), .rsp_full_i (rsp_full),
    .avl_ready_i (avl_ready_i), .avl_addr_o (avl_addr_o), .avl_wdata_o (avl_wdata_o),
    .avl_read_req_o (avl_read_req_o), .avl_write_req_o (avl_write_req_o),
    .avl_size_o (avl_size_o), .avl_rdata_valid_i (avl_rdata_valid_i),
    .avl_rdata_i (avl_rdata_i)
  );

endmodule

`default_nettype wire

/* design/req_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_port_cfg.svh"

module req_arbiter (
  input  wire logic                   clk_i,
  input  wire logic                   rst_i,

  input  wire logic                   inst_stb_i,
  input  wire mem_port_pkg::mem_addr_t inst_adr_i,
  output logic                        inst_stall_o,
  output logic                        inst_ack_o,
  output mem_port_pkg::mem_data_t     inst_rdat_o,

  input  wire logic                   data_stb_i,
  input  wire logic                   data_we_i,
  input  wire mem_port_pkg::mem_addr_t data_adr_i,
  input  wire mem_port_pkg::mem_data_t data_wdat_i,
  output logic                        data_stall_o,
  output logic                        data_ack_o,
  output mem_port_pkg::mem_data_t     data_rdat_o,

  output logic                        cmd_push_o,
  output mem_port_pkg::mem_cmd_t      cmd_o,
  input  wire logic                   cmd_full_i,

  output logic                        rsp_pop_o,
  input  wire mem_port_pkg::mem_data_t rsp_i,
  input  wire logic                   rsp_empty_i
);

  localparam int WE_BIT = `MEM_ADDR_W + `MEM_DATA_W;

  mem_port_pkg::arb_state_t state_q;
  mem_port_pkg::mem_cmd_t   cmd_q;
  logic                     prefer_data_q;
  logic                     owner_data_q; // port that owns the command in flight
  logic                     grant_inst;
  logic                     grant_data;
  logic                     is_write;
  logic                     done;

  // favored port wins a tie, the other one only gets in when the favored is quiet
  assign grant_inst = (state_q == mem_port_pkg::ARB_IDLE) && inst_stb_i &&
                      (!prefer_data_q || !data_stb_i);
  assign grant_data = (state_q == mem_port_pkg::ARB_IDLE) && data_stb_i &&
                      (prefer_data_q || !inst_stb_i);

  assign inst_stall_o = (state_q != mem_port_pkg::ARB_IDLE) || grant_data;
  assign data_stall_o = (state_q != mem_port_pkg::ARB_IDLE) || grant_inst;

  assign is_write   = cmd_q[WE_BIT];
  assign cmd_o      = cmd_q;
  assign cmd_push_o = (state_q == mem_port_pkg::ARB_POST) && !cmd_full_i;
  assign rsp_pop_o  = (state_q == mem_port_pkg::ARB_WAIT_RSP) && !rsp_empty_i;

  // writes are done once posted, reads once their data leaves the response FIFO
  assign done = (cmd_push_o && is_write) || rsp_pop_o;

  assign inst_ack_o  = done && !owner_data_q;
  assign data_ack_o  = done && owner_data_q;
  assign inst_rdat_o = rsp_i;
  assign data_rdat_o = rsp_i;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      state_q       <= mem_port_pkg::ARB_IDLE;
      prefer_data_q <= 1'b0;
      owner_data_q  <= 1'b0;
    end
    else
    begin
      case (state_q)
        mem_port_pkg::ARB_IDLE:
          if (grant_inst || grant_data)
          begin
            owner_data_q  <= grant_data;
            prefer_data_q <= grant_inst; // the port just served goes to the back
            state_q       <= mem_port_pkg::ARB_POST;
          end
        mem_port_pkg::ARB_POST:
          if (!cmd_full_i)
            state_q <= is_write ? mem_port_pkg::ARB_IDLE : mem_port_pkg::ARB_WAIT_RSP;
        mem_port_pkg::ARB_WAIT_RSP:
          if (!rsp_empty_i)
            state_q <= mem_port_pkg::ARB_IDLE;
        default:
          state_q <= mem_port_pkg::ARB_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (grant_data)
      cmd_q <= {data_we_i, data_adr_i, data_wdat_i};
    else if (grant_inst)
      cmd_q <= {1'b0, inst_adr_i, mem_port_pkg::mem_data_t'(0)}; // instruction side only reads
  end

  // each grant ends in a single ack pulse before the next one can start
  a_one_ack: assert property (@(posedge clk_i) disable iff (rst_i)
    (inst_ack_o || data_ack_o) |=> !inst_ack_o && !data_ack_o);

endmodule

`default_nettype wire

/* design/sync_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input  wire logic             clk_i,
  input  wire logic             rst_i,
  input  wire logic             push_i,
  input  wire logic [WIDTH-1:0] din_i,
  output logic                  full_o,
  input  wire logic             pop_i,
  output logic      [WIDTH-1:0] dout_o,
  output logic                  empty_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  // wraps at DEPTH so depths that are not a power of two work too
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;
  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);
  assign dout_o  = mem_q[rd_ptr_q]; // head word, valid whenever not empty

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr_q <= next_ptr(wr_ptr_q);
      if (do_pop)
        rd_ptr_q <= next_ptr(rd_ptr_q);
      if (do_push && !do_pop)
        count_q <= count_q + 1'b1;
      else if (do_pop && !do_push)
        count_q <= count_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (do_push)
      mem_q[wr_ptr_q] <= din_i;
  end

  a_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i) push_i |-> !full_o);
  a_no_underflow: assert property (@(posedge clk_i) disable iff (rst_i) pop_i |-> !empty_o);

endmodule

`default_nettype wire

/* verification/avl_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module avl_mem_model (
  input  wire logic                    clk_i,
  input  wire logic                    hold_ready_i,
  output logic                         avl_ready_o,
  input  wire mem_port_pkg::mem_addr_t avl_addr_i,
  input  wire mem_port_pkg::mem_data_t avl_wdata_i,
  input  wire logic                    avl_read_req_i,
  input  wire logic                    avl_write_req_i,
  output logic                         avl_rdata_valid_o,
  output mem_port_pkg::mem_data_t      avl_rdata_o
);

  mem_port_pkg::mem_data_t mem [mem_port_pkg::mem_addr_t]; // only written words are stored
  mem_port_pkg::mem_addr_t rd_addr;
  integer                  seed = 32'h9fe8;
  int                      rd_wait;
  logic                    hold_q;

  // every lane carries the whole address so aliasing shows up as a mismatch
  function automatic mem_port_pkg::mem_data_t init_word(input mem_port_pkg::mem_addr_t a);
    return {6'h11, a, 6'h22, ~a, 6'h33, a ^ 26'h155_5555, 6'h0c, a[12:0], a[25:13]};
  endfunction

  initial
  begin
    avl_ready_o       = 1'b0;
    avl_rdata_valid_o = 1'b0;
    avl_rdata_o       = '0;
    rd_addr           = '0;
    rd_wait           = 0;
    hold_q            = 1'b0;
    forever
    begin
      @(negedge clk_i); // the next rising edge acts on what is settled here
      hold_q = hold_ready_i;
      if (avl_ready_o && avl_write_req_i)
        mem[avl_addr_i] = avl_wdata_i;
      if (avl_ready_o && avl_read_req_i)
      begin
        rd_addr = avl_addr_i;
        rd_wait = 1 + ($unsigned($random(seed)) % 6);
      end
      @(posedge clk_i);
      #1;
      avl_rdata_valid_o = 1'b0;
      if (rd_wait > 0)
      begin
        rd_wait = rd_wait - 1;
        if (rd_wait == 0)
        begin
          avl_rdata_valid_o = 1'b1;
          avl_rdata_o       = mem.exists(rd_addr) ? mem[rd_addr] : init_word(rd_addr);
        end
      end
      avl_ready_o = !hold_q && (($unsigned($random(seed)) % 4) != 0);
    end
  end

endmodule

`default_nettype wire

/* verification/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int RESET_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_o
);

  initial
  begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o; // 100 ns period
  end

  initial
  begin
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1 rst_o = 1'b0;
  end

endmodule

`default_nettype wire

/* verification/tb_mem_port.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_port_cfg.svh"

module tb_mem_port;

  localparam int NUM_OPS        = 400;
  localparam int OP_BOUND       = 50; // cycles one operation may take at most
  localparam int TIMEOUT_CYCLES = NUM_OPS * OP_BOUND;
  localparam mem_port_pkg::mem_addr_t INST_BASE  = 26'h2000;
  localparam mem_port_pkg::mem_addr_t DATA_BASE  = 26'h3000;
  localparam mem_port_pkg::mem_addr_t BURST_BASE = 26'h4000;

  logic                    clk;
  logic                    rst;
  logic                    flush;
  logic                    inst_stb;
  mem_port_pkg::mem_addr_t inst_adr;
  logic                    inst_stall;
  logic                    inst_ack;
  mem_port_pkg::mem_data_t inst_rdat;
  logic                    data_stb;
  logic                    data_we;
  mem_port_pkg::mem_addr_t data_adr;
  mem_port_pkg::mem_data_t data_wdat;
  logic                    data_stall;
  logic                    data_ack;
  mem_port_pkg::mem_data_t data_rdat;
  logic                    avl_ready;
  mem_port_pkg::mem_addr_t avl_addr;
  mem_port_pkg::mem_data_t avl_wdata;
  logic                    avl_read_req;
  logic                    avl_write_req;
  logic              [8:0] avl_size;
  logic                    avl_rdata_valid;
  mem_port_pkg::mem_data_t avl_rdata;
  logic                    hold_ready;

  // shadow of the memory and a copy of the cache contents
  mem_port_pkg::mem_data_t shadow [mem_port_pkg::mem_addr_t];
  logic                    line_valid [`ICACHE_LINES];
  mem_port_pkg::mem_addr_t line_addr [`ICACHE_LINES];
  mem_port_pkg::mem_data_t line_data [`ICACHE_LINES];
  mem_port_pkg::mem_data_t exp_inst_q [$];
  mem_port_pkg::mem_data_t exp_data_q [$];
  logic                    exp_data_we_q [$];
  int inst_acks = 0;
  int data_acks = 0;
  int inst_accepts = 0;
  int data_accepts = 0;
  int avl_reads = 0;
  int avl_writes = 0;
  int exp_avl_reads = 0;
  int exp_avl_writes = 0;
  int cycles = 0;
  integer seed = 32'h9fe8;

  tb_clk_gen clk_gen_i (.clk_o (clk), .rst_o (rst));

  mem_port_top dut_i (
    .clk (clk), .rst (rst), .flush_i (flush),
    .inst_stb_i (inst_stb), .inst_adr_i (inst_adr), .inst_stall_o (inst_stall),
    .inst_ack_o (inst_ack), .inst_rdat_o (inst_rdat),
    .data_stb_i (data_stb), .data_we_i (data_we), .data_adr_i (data_adr),
    .data_wdat_i (data_wdat), .data_stall_o (data_stall),
    .data_ack_o (data_ack), .data_rdat_o (data_rdat),
    .avl_ready_i (avl_ready), .avl_addr_o (avl_addr), .avl_wdata_o (avl_wdata),
    .avl_read_req_o (avl_read_req), .avl_write_req_o (avl_write_req),
    .avl_size_o (avl_size), .avl_rdata_valid_i (avl_rdata_valid), .avl_rdata_i (avl_rdata)
  );

  avl_mem_model mem_model_i (
    .clk_i (clk), .hold_ready_i (hold_ready), .avl_ready_o (avl_ready),
    .avl_addr_i (avl_addr), .avl_wdata_i (avl_wdata), .avl_read_req_i (avl_read_req),
    .avl_write_req_i (avl_write_req), .avl_rdata_valid_o (avl_rdata_valid),
    .avl_rdata_o (avl_rdata)
  );

  function automatic mem_port_pkg::mem_data_t init_word(input mem_port_pkg::mem_addr_t a);
    return {6'h11, a, 6'h22, ~a, 6'h33, a ^ 26'h155_5555, 6'h0c, a[12:0], a[25:13]};
  endfunction

  function automatic mem_port_pkg::mem_data_t expected_word(input mem_port_pkg::mem_addr_t a);
    return shadow.exists(a) ? shadow[a] : init_word(a);
  endfunction

  function automatic mem_port_pkg::mem_data_t rand_word();
    return {$random(seed), $random(seed), $random(seed), $random(seed)};
  endfunction

  task automatic stop_run(input string what);
    $display("error at %0t: %s", $time, what);
    $display("Simulation failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_data(input mem_port_pkg::mem_data_t got,
                            input mem_port_pkg::mem_data_t exp, input string what);
    if (got !== exp)
    begin
      $display("FAIL %0t: %s returned %h, expected %h", $time, what, got, exp);
      $display("Simulation failed");
      $fatal(1, "data mismatch");
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp)
    begin
      $display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp);
      $display("Simulation failed");
      $fatal(1, "count mismatch");
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp)
    begin
      $display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
      $display("Simulation failed");
      $fatal(1, "flag mismatch");
    end
  endtask

  // a hit returns the line as last filled, a miss refills it from memory
  task automatic inst_read(input mem_port_pkg::mem_addr_t a);
    int idx;
    idx      = int'(a) % `ICACHE_LINES;
    inst_stb = 1'b1;
    inst_adr = a;
    do @(negedge clk); while (inst_stall);
    if (!(line_valid[idx] && line_addr[idx] == a))
    begin
      line_valid[idx] = 1'b1;
      line_addr[idx]  = a;
      line_data[idx]  = expected_word(a);
      exp_avl_reads++;
    end
    exp_inst_q.push_back(line_data[idx]);
    @(posedge clk);
    #1;
    inst_stb = 1'b0;
  endtask

  task automatic data_req(input logic we, input mem_port_pkg::mem_addr_t a,
                          input mem_port_pkg::mem_data_t d);
    data_stb  = 1'b1;
    data_we   = we;
    data_adr  = a;
    data_wdat = d;
    do @(negedge clk); while (data_stall);
    exp_data_we_q.push_back(we);
    exp_data_q.push_back(we ? d : expected_word(a));
    if (we)
    begin
      shadow[a] = d; // posted writes stay ordered ahead of later reads
      exp_avl_writes++;
    end
    else
      exp_avl_reads++;
    @(posedge clk);
    #1;
    data_stb = 1'b0;
  endtask

  task automatic wait_idle();
    while (exp_inst_q.size() != 0 || exp_data_q.size() != 0 ||
           avl_writes < exp_avl_writes) // posted writes also have to reach memory
      @(posedge clk);
    repeat (2) @(posedge clk);
    #1;
  endtask

  task automatic flush_cache();
    flush = 1'b1;
    @(posedge clk);
    #1;
    flush = 1'b0;
    foreach (line_valid[i])
      line_valid[i] = 1'b0;
  endtask

  always @(negedge clk)
  begin
    logic                    was_write;
    mem_port_pkg::mem_data_t exp_word;
    if (!rst)
    begin
      if (inst_stb && !inst_stall)
        inst_accepts++;
      if (data_stb && !data_stall)
        data_accepts++;
      if (avl_read_req && avl_ready)
        avl_reads++;
      if (avl_write_req && avl_ready)
        avl_writes++;
      if (inst_ack)
      begin
        if (exp_inst_q.size() == 0)
          stop_run("instruction ack without a pending request");
        else
        begin
          check_data(inst_rdat, exp_inst_q.pop_front(), "instruction read");
          inst_acks++;
        end
      end
      if (data_ack)
      begin
        if (exp_data_q.size() == 0)
          stop_run("data ack without a pending request");
        else
        begin
          was_write = exp_data_we_q.pop_front();
          exp_word  = exp_data_q.pop_front();
          if (!was_write)
            check_data(data_rdat, exp_word, "data read");
          data_acks++;
        end
      end
    end
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES)
      stop_run("timeout, the tests did not finish within the cycle limit");
  end

  initial
  begin
    mem_port_pkg::mem_addr_t inst_addrs [150];
    mem_port_pkg::mem_data_t word;
    int                      reads0;
    int                      acks0;
    flush      = 1'b0;
    inst_stb   = 1'b0;
    inst_adr   = '0;
    data_stb   = 1'b0;
    data_we    = 1'b0;
    data_adr   = '0;
    data_wdat  = '0;
    hold_ready = 1'b0;
    foreach (line_valid[i])
      line_valid[i] = 1'b0;
    @(negedge rst);

    repeat (6)
    begin
      @(negedge clk);
      check_flag(avl_read_req, 1'b0, "avl read request after reset");
      check_flag(avl_write_req, 1'b0, "avl write request after reset");
      check_flag(inst_ack, 1'b0, "instruction ack after reset");
      check_flag(data_ack, 1'b0, "data ack after reset");
      check_flag(inst_stall, 1'b0, "instruction stall after reset");
      check_flag(data_stall, 1'b0, "data stall after reset");
    end
    check_count(int'(avl_size), 1, "avl burst size");
    @(posedge clk);
    #1;

    word = rand_word();
    data_req(1'b1, 26'h40, word);
    data_req(1'b0, 26'h40, '0);
    data_req(1'b0, 26'h41, '0); // never written
    wait_idle();

    reads0 = avl_reads;
    inst_read(26'h1000);
    wait_idle();
    check_count(avl_reads, reads0 + 1, "Avalon reads for an instruction miss");
    inst_read(26'h1000);
    wait_idle();
    check_count(avl_reads, reads0 + 1, "Avalon reads after an instruction hit");

    // the cache keeps the old word until it is flushed
    data_req(1'b1, 26'h1000, rand_word());
    wait_idle();
    inst_read(26'h1000);
    wait_idle();
    flush_cache();
    inst_read(26'h1000);
    wait_idle();

    for (int i = 0; i < 150; i++)
      inst_addrs[i] = INST_BASE + mem_port_pkg::mem_addr_t'($unsigned($random(seed)) % 48);
    fork
      for (int i = 0; i < 150; i++)
        inst_read(inst_addrs[i]);
      for (int i = 0; i < 150; i++)
        data_req($random(seed) % 2 != 0,
                 DATA_BASE + mem_port_pkg::mem_addr_t'($unsigned($random(seed)) % 32),
                 rand_word());
    join
    wait_idle();

    hold_ready = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    acks0 = data_acks;
    fork
      for (int i = 0; i < 8; i++)
        data_req(1'b1, BURST_BASE + mem_port_pkg::mem_addr_t'(i), rand_word());
      begin
        repeat (40) @(posedge clk);
        @(negedge clk);
        // one command waits in the sequencer, the FIFO holds the rest
        check_count(data_acks - acks0, `CMD_FIFO_DEPTH + 1, "writes posted while not ready");
        check_flag(data_stall, 1'b1, "data stall with a full command FIFO");
        check_flag(avl_write_req, 1'b1, "avl write request held while not ready");
        @(posedge clk);
        #1;
        hold_ready = 1'b0;
      end
    join
    wait_idle();
    for (int i = 0; i < 8; i++)
      data_req(1'b0, BURST_BASE + mem_port_pkg::mem_addr_t'(i), '0);
    wait_idle();

    check_count(inst_acks, inst_accepts, "instruction acks against accepted requests");
    check_count(data_acks, data_accepts, "data acks against accepted requests");
    check_count(avl_reads, exp_avl_reads, "Avalon reads");
    check_count(avl_writes, exp_avl_writes, "Avalon writes");
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+design
design/mem_port_pkg.sv
design/sync_fifo.sv
design/req_arbiter.sv
design/avl_sequencer.sv
design/icache.sv
design/mem_port_top.sv
verification/tb_clk_gen.sv
verification/avl_mem_model.sv
verification/tb_mem_port.sv
